/* common/axi_rd_pkg.sv */
package axi_rd_pkg;

    localparam int AXI_ADDR_W   = 32;
    localparam int AXI_DATA_W   = 32;
    localparam int AXI_ID_W     = 4;
    localparam int CACHE_BYTES  = 64;
    localparam int CACHE_ADDR_W = 6;

    typedef logic [AXI_ADDR_W-1:0]   axi_addr_t;
    typedef logic [AXI_DATA_W-1:0]   axi_data_t;
    typedef logic [AXI_ID_W-1:0]     axi_id_t;
    // Number of beats minus one
    typedef logic [3:0]              axi_len_t;
    // Log2 of bytes per beat
    typedef logic [2:0]              axi_size_t;
    typedef logic [CACHE_ADDR_W-1:0] cache_addr_t;
    typedef logic [AXI_DATA_W/8-1:0] byte_en_t;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    // Larger code means a worse response
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_e burst;
    } rd_cmd_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_e resp;
        logic      last;
    } r_beat_t;

    typedef struct packed {
        cache_addr_t addr;
        byte_en_t    be;
        axi_data_t   data;
    } cache_wr_t;

endpackage

/* design/ar_issue.sv */
`timescale 1ns/1ps

module ar_issue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_valid_i,
    input  axi_rd_pkg::rd_cmd_t cmd_i,
    input  logic                arready_i,
    input  logic                burst_done_i,
    output logic                cmd_ready_o,
    output logic                arvalid_o,
    output axi_rd_pkg::rd_cmd_t ar_o,
    output axi_rd_pkg::rd_cmd_t cmd_o,
    output logic                start_o
);
    import axi_rd_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        WAIT_DATA
    } state_e;

    state_e  state_q;
    state_e  state_d;
    rd_cmd_t cmd_q;
    logic    cmd_hs;
    logic    ar_hs;

    assign cmd_ready_o = (state_q == IDLE);
    assign arvalid_o   = (state_q == ADDR);
    assign cmd_hs      = cmd_valid_i & cmd_ready_o;
    assign ar_hs       = arvalid_o & arready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cmd_hs) begin
                    state_d = ADDR;
                end
            end
            ADDR: begin
                if (ar_hs) begin
                    state_d = WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                if (burst_done_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Held from acceptance until the collector finishes
    always_ff @(posedge clk) begin
        if (cmd_hs) begin
            cmd_q <= cmd_i;
        end
    end

    assign ar_o    = cmd_q;
    assign cmd_o   = cmd_q;
    // Collector starts on the address handshake
    assign start_o = ar_hs;

endmodule

/* design/r_collect/r_collect.sv */
`timescale 1ns/1ps

module r_collect (
    input  logic                       clk,
    input  logic                       rst_n,
    input  axi_rd_pkg::rd_cmd_t        cmd_i,
    input  logic                       start_i,
    input  logic                       rvalid_i,
    input  axi_rd_pkg::r_beat_t        r_i,
    output logic                       rready_o,
    output axi_rd_pkg::cache_wr_t      cache_wr_o,
    output logic                       cache_we_o,
    output logic                       burst_done_o,
    output axi_rd_pkg::axi_resp_e      resp_o
);
    import axi_rd_pkg::*;

    typedef enum logic {
        IDLE,
        COLLECT
    } state_e;

    state_e      state_q;
    cache_addr_t beat_addr_q;
    cache_addr_t wrap_mask_q;
    cache_addr_t wrap_mask_d;
    cache_addr_t step;
    cache_addr_t incr_addr;
    cache_addr_t next_addr;
    logic [6:0]  burst_bytes;
    byte_en_t    beat_be;
    axi_resp_e   resp_acc_q;
    axi_resp_e   resp_merged;
    logic        beat_hs;

    assign rready_o = (state_q == COLLECT);
    assign beat_hs  = rvalid_i & rready_o;

    // Total burst bytes give the wrap block size
    assign burst_bytes = ({3'b000, cmd_i.len} + 7'd1) << cmd_i.size;
    assign wrap_mask_d = cache_addr_t'(burst_bytes - 7'd1);

    assign step      = cache_addr_t'(1) << cmd_i.size;
    assign incr_addr = beat_addr_q + step;

    always_comb begin
        case (cmd_i.burst)
            BURST_FIXED: begin
                next_addr = beat_addr_q;
            end
            BURST_WRAP: begin
                next_addr = (beat_addr_q & ~wrap_mask_q) | (incr_addr & wrap_mask_q);
            end
            default: begin
                next_addr = incr_addr;
            end
        endcase
    end

    always_comb begin
        case (cmd_i.size)
            3'd0:    beat_be = 4'b0001;
            3'd1:    beat_be = 4'b0011;
            default: beat_be = 4'b1111;
        endcase
    end

    // Keep the worse of the running and current response
    assign resp_merged = (r_i.resp > resp_acc_q) ? r_i.resp : resp_acc_q;

    assign cache_we_o      = beat_hs;
    assign cache_wr_o.addr = beat_addr_q;
    assign cache_wr_o.be   = beat_be;
    assign cache_wr_o.data = r_i.data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            burst_done_o <= 1'b0;
            resp_acc_q   <= RESP_OKAY;
            resp_o       <= RESP_OKAY;
        end else begin
            burst_done_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q    <= COLLECT;
                        resp_acc_q <= RESP_OKAY;
                    end
                end
                COLLECT: begin
                    if (beat_hs) begin
                        resp_acc_q <= resp_merged;
                        if (r_i.last) begin
                            state_q      <= IDLE;
                            burst_done_o <= 1'b1;
                            resp_o       <= resp_merged;
                        end
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            beat_addr_q <= cache_addr_t'(cmd_i.addr);
            wrap_mask_q <= wrap_mask_d;
        end else if (beat_hs) begin
            beat_addr_q <= next_addr;
        end
    end

endmodule

/* design/burst_cache.sv */
`timescale 1ns/1ps

module burst_cache (
    input  logic                    clk,
    input  logic                    rst_n,
    input  axi_rd_pkg::cache_wr_t   wr_i,
    input  logic                    we_i,
    input  axi_rd_pkg::cache_addr_t rd_addr_i,
    output axi_rd_pkg::axi_data_t   rd_data_o
);
    import axi_rd_pkg::*;

    localparam int LANES = $bits(byte_en_t);

    logic [7:0]  mem [CACHE_BYTES];
    cache_addr_t wr_lane_addr [LANES];
    cache_addr_t rd_lane_addr [LANES];

    // Lane addresses roll over at the top of the cache
    for (genvar k = 0; k < LANES; k++) begin : g_lane
        assign wr_lane_addr[k] = wr_i.addr + cache_addr_t'(k);
        assign rd_lane_addr[k] = rd_addr_i + cache_addr_t'(k);
        assign rd_data_o[8*k +: 8] = mem[rd_lane_addr[k]];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < CACHE_BYTES; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (we_i) begin
            for (int k = 0; k < LANES; k++) begin
                if (wr_i.be[k]) begin
                    mem[wr_lane_addr[k]] <= wr_i.data[8*k +: 8];
                end
            end
        end
    end

endmodule

/* design/axi_rd_master.sv */
`timescale 1ns/1ps

module axi_rd_master (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_valid_i,
    input  axi_rd_pkg::rd_cmd_t     cmd_i,
    output logic                    cmd_ready_o,
    output logic                    arvalid_o,
    output axi_rd_pkg::rd_cmd_t     ar_o,
    input  logic                    arready_i,
    input  logic                    rvalid_i,
    input  axi_rd_pkg::r_beat_t     r_i,
    output logic                    rready_o,
    output logic                    rd_done_o,
    output axi_rd_pkg::axi_resp_e   rd_resp_o,
    input  axi_rd_pkg::cache_addr_t cache_addr_i,
    output axi_rd_pkg::axi_data_t   cache_data_o
);
    import axi_rd_pkg::*;

    rd_cmd_t   cmd_q;
    logic      start;
    logic      burst_done;
    cache_wr_t cache_wr;
    logic      cache_we;

    ar_issue u_ar_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .arready_i    (arready_i),
        .burst_done_i (burst_done),
        .cmd_ready_o  (cmd_ready_o),
        .arvalid_o    (arvalid_o),
        .ar_o         (ar_o),
        .cmd_o        (cmd_q),
        .start_o      (start)
    );

    r_collect u_r_collect (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_i        (cmd_q),
        .start_i      (start),
        .rvalid_i     (rvalid_i),
        .r_i          (r_i),
        .rready_o     (rready_o),
        .cache_wr_o   (cache_wr),
        .cache_we_o   (cache_we),
        .burst_done_o (burst_done),
        .resp_o       (rd_resp_o)
    );

    burst_cache u_burst_cache (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_i      (cache_wr),
        .we_i      (cache_we),
        .rd_addr_i (cache_addr_i),
        .rd_data_o (cache_data_o)
    );

    assign rd_done_o = burst_done;

endmodule

/* bench/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release lands just after an edge, away from the sampling point
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

/* bench/axi_rd_master_asserts.sv */
`timescale 1ns/1ps

module axi_rd_master_asserts (
    input logic                clk,
    input logic                rst_n,
    input logic                cmd_valid_i,
    input axi_rd_pkg::rd_cmd_t cmd_i,
    input logic                cmd_ready_i,
    input logic                arvalid_i,
    input axi_rd_pkg::rd_cmd_t ar_i,
    input logic                arready_i,
    input logic                rvalid_i,
    input logic                rready_i,
    input logic                cache_we_i,
    input logic                rd_done_i
);
    import axi_rd_pkg::*;

    // User holds its command until accepted
    cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid_i && !cmd_ready_i |=> cmd_valid_i && $stable(cmd_i))
        else $error("command changed or dropped while waiting for cmd_ready_o");

    ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
        else $error("AR payload changed or arvalid_o dropped before arready_i");

    // Cache writes only happen while the issuer waits for data
    write_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
        cache_we_i |-> !cmd_ready_i && !arvalid_i)
        else $error("cache written outside a burst");

    no_collect_before_ar: assert property (@(posedge clk) disable iff (!rst_n)
        rready_i |-> !arvalid_i)
        else $error("rready_o high while the address is still pending");

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        rd_done_i |=> !rd_done_i)
        else $error("rd_done_o held longer than one cycle");

    legal_size: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid_i |-> cmd_i.size <= 3'd2)
        else $error("command size above 4 bytes per beat");

    legal_wrap_len: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid_i && cmd_i.burst == BURST_WRAP |-> cmd_i.len inside {4'd1, 4'd3, 4'd7, 4'd15})
        else $error("WRAP command with an illegal length");

endmodule

/* bench/tb_axi_rd_master.sv */
`timescale 1ns/1ps

module tb_axi_rd_master;
    import axi_rd_pkg::*;

    localparam int NUM_TESTS    = 8;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 2;

    // One table row per burst with its AR delay in cycles and largest R beat gap
    typedef struct packed {
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_e burst;
        axi_resp_e  resp;
        logic [3:0] ar_delay;
        logic [1:0] gap_max;
    } test_vec_t;

    logic        clk;
    logic        rst_n;
    logic        cmd_valid_i;
    rd_cmd_t     cmd_i;
    logic        cmd_ready_o;
    logic        arvalid_o;
    rd_cmd_t     ar_o;
    logic        arready_i;
    logic        rvalid_i;
    r_beat_t     r_i;
    logic        rready_o;
    logic        rd_done_o;
    axi_resp_e   rd_resp_o;
    cache_addr_t cache_addr_i;
    axi_data_t   cache_data_o;

    test_vec_t   tests [NUM_TESTS];
    logic [7:0]  ref_mem [CACHE_BYTES];
    logic [31:0] rng_state = 32'hf6be38bd;
    logic        table_loaded = 1'b0;
    int          err_count = 0;
    int          check_count = 0;
    int          done_count = 0;
    int          ar_count = 0;
    int          cycle_count = 0;

    clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    axi_rd_master UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .cmd_ready_o  (cmd_ready_o),
        .arvalid_o    (arvalid_o),
        .ar_o         (ar_o),
        .arready_i    (arready_i),
        .rvalid_i     (rvalid_i),
        .r_i          (r_i),
        .rready_o     (rready_o),
        .rd_done_o    (rd_done_o),
        .rd_resp_o    (rd_resp_o),
        .cache_addr_i (cache_addr_i),
        .cache_data_o (cache_data_o)
    );

    bind axi_rd_master axi_rd_master_asserts u_asserts (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .cmd_ready_i (cmd_ready_o),
        .arvalid_i   (arvalid_o),
        .ar_i        (ar_o),
        .arready_i   (arready_i),
        .rvalid_i    (rvalid_i),
        .rready_i    (rready_o),
        .cache_we_i  (cache_we),
        .rd_done_i   (rd_done_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic load_table();
        tests[0] = '{32'h0000_0105, 4'd7,  3'd0, BURST_INCR,  RESP_OKAY,   4'd0, 2'd0};
        tests[1] = '{32'h0000_2022, 4'd3,  3'd1, BURST_INCR,  RESP_OKAY,   4'd1, 2'd1};
        // Runs off the top of the cache
        tests[2] = '{32'h0000_003a, 4'd5,  3'd2, BURST_INCR,  RESP_OKAY,   4'd0, 2'd2};
        tests[3] = '{32'h0000_0410, 4'd3,  3'd2, BURST_FIXED, RESP_OKAY,   4'd2, 2'd1};
        tests[4] = '{32'h0000_0028, 4'd3,  3'd2, BURST_WRAP,  RESP_OKAY,   4'd0, 2'd3};
        tests[5] = '{32'h0000_0030, 4'd1,  3'd2, BURST_INCR,  RESP_SLVERR, 4'd6, 2'd0};
        tests[6] = '{32'h0000_1036, 4'd7,  3'd1, BURST_WRAP,  RESP_OKAY,   4'd3, 2'd2};
        tests[7] = '{32'h0000_0004, 4'd15, 3'd2, BURST_INCR,  RESP_OKAY,   4'd9, 2'd1};
    endtask

    function automatic int cycle_limit();
        int total;
        total = RESET_CYCLES;
        for (int n = 0; n < NUM_TESTS; n++) begin
            total += (int'(tests[n].len) + 1) * 64;
        end
        return total;
    endfunction

    // Cache byte address of beat i under the burst rules
    function automatic int beat_address(input test_vec_t t, input int i);
        int bytes;
        int start;
        int block;
        int base;
        bytes = 1 << t.size;
        start = int'(t.addr[5:0]);
        case (t.burst)
            BURST_FIXED: return start;
            BURST_WRAP: begin
                block = (int'(t.len) + 1) * bytes;
                base  = start - (start % block);
                return base + ((start - base + i * bytes) % block);
            end
            default: return (start + i * bytes) % CACHE_BYTES;
        endcase
    endfunction

    task automatic write_ref_beat(input int addr, input axi_size_t size, input axi_data_t data);
        for (int k = 0; k < (1 << size); k++) begin
            ref_mem[(addr + k) % CACHE_BYTES] = data[8*k +: 8];
        end
    endtask

    task automatic sweep_cache();
        logic [31:0] exp;
        for (int a = 0; a < CACHE_BYTES; a++) begin
            cache_addr_i = cache_addr_t'(a);
            #1;
            exp = {ref_mem[(a + 3) % CACHE_BYTES], ref_mem[(a + 2) % CACHE_BYTES],
                   ref_mem[(a + 1) % CACHE_BYTES], ref_mem[a]};
            check_value($sformatf("cache_data_o at %0d", a), cache_data_o, exp);
            next_cycle();
        end
    endtask

    task automatic run_burst(input int n);
        test_vec_t t;
        rd_cmd_t   cmd;
        r_beat_t   beat;
        axi_resp_e worst;
        int        beats;
        int        gap;
        t          = tests[n];
        cmd.id     = axi_id_t'(n);
        cmd.addr   = t.addr;
        cmd.len    = t.len;
        cmd.size   = t.size;
        cmd.burst  = t.burst;
        beats      = int'(t.len) + 1;
        worst      = RESP_OKAY;

        cmd_valid_i = 1'b1;
        cmd_i       = cmd;
        while (!cmd_ready_o) next_cycle();
        next_cycle();
        cmd_valid_i = 1'b0;
        check_value("arvalid_o after command", arvalid_o, 1'b1);

        // Address channel held off by the slave
        repeat (t.ar_delay) begin
            check_value("ar_o while arready_i low", ar_o, cmd);
            next_cycle();
        end
        arready_i = 1'b1;
        while (!arvalid_o) next_cycle();
        check_value("ar_o at handshake", ar_o, cmd);
        next_cycle();
        arready_i = 1'b0;
        check_value("arvalid_o after handshake", arvalid_o, 1'b0);

        for (int i = 0; i < beats; i++) begin
            rng_state = xorshift32(rng_state);
            gap = int'(rng_state % (int'(t.gap_max) + 1));
            repeat (gap) next_cycle();
            rng_state  = xorshift32(rng_state);
            beat.id    = cmd.id;
            beat.data  = rng_state;
            beat.resp  = (i == int'(t.len) / 2) ? t.resp : RESP_OKAY;
            beat.last  = (i == beats - 1);
            rvalid_i   = 1'b1;
            r_i        = beat;
            while (!rready_o) next_cycle();
            next_cycle();
            rvalid_i = 1'b0;
            write_ref_beat(beat_address(t, i), t.size, beat.data);
            if (beat.resp > worst) begin
                worst = beat.resp;
            end
        end

        while (!rd_done_o) next_cycle();
        check_value("rd_resp_o", rd_resp_o, worst);
        check_value("cmd_ready_o during rd_done_o", cmd_ready_o, 1'b0);
        next_cycle();
        check_value("cmd_ready_o after rd_done_o", cmd_ready_o, 1'b1);
        check_value("rd_done_o pulse length", rd_done_o, 1'b0);
        check_value("rready_o after burst", rready_o, 1'b0);
        check_value("rd_done_o pulses so far", done_count, n + 1);
        sweep_cache();
    endtask

    // Handshake counts taken mid-cycle where the signals are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (rd_done_o) begin
                done_count++;
            end
            if (arvalid_o && arready_i) begin
                ar_count++;
            end
        end
    end

    initial begin
        int limit;
        wait (table_loaded);
        limit = cycle_limit();
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the bursts did not complete within %0d cycles", limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        cmd_valid_i  = 1'b0;
        cmd_i        = '0;
        arready_i    = 1'b0;
        rvalid_i     = 1'b0;
        r_i          = '0;
        cache_addr_i = '0;
        for (int i = 0; i < CACHE_BYTES; i++) begin
            ref_mem[i] = 8'h00;
        end
        load_table();
        table_loaded = 1'b1;

        @(posedge rst_n);
        next_cycle();
        check_value("cmd_ready_o after reset", cmd_ready_o, 1'b1);
        check_value("arvalid_o after reset", arvalid_o, 1'b0);
        check_value("rready_o after reset", rready_o, 1'b0);
        check_value("rd_done_o after reset", rd_done_o, 1'b0);
        sweep_cache();

        for (int n = 0; n < NUM_TESTS; n++) begin
            run_burst(n);
        end
        check_value("total rd_done_o pulses", done_count, NUM_TESTS);
        check_value("total AR handshakes", ar_count, NUM_TESTS);

        $display("checks: %0d  errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
common/axi_rd_pkg.sv
design/ar_issue.sv
design/r_collect/r_collect.sv
design/burst_cache.sv
design/axi_rd_master.sv
bench/clk_gen.sv
bench/axi_rd_master_asserts.sv
bench/tb_axi_rd_master.sv

/* Bender.yml */
package:
  name: axi_rd_master

sources:
  - files:
      - common/axi_rd_pkg.sv
      - design/ar_issue.sv
      - design/r_collect/r_collect.sv
      - design/burst_cache.sv
      - design/axi_rd_master.sv
  - target: simulation
    files:
      - bench/clk_gen.sv
      - bench/axi_rd_master_asserts.sv
      - bench/tb_axi_rd_master.sv
